// File: source/crop_defines.svh
//************************************************
// crop tracker constants
// counter width, key step sizes and the forced
// blank margins around the raster
//************************************************

`ifndef CROP_DEFINES_SVH
`define CROP_DEFINES_SVH

// raster counters and crop offsets
`define CROP_CNT_W 12

// offset change per arrow key press
`define CROP_H_STEP 4
`define CROP_V_STEP 1

// forced blank margins
`define CROP_H_EDGE 8     // clocks at both ends of a line
`define CROP_SHBL_LEAD 2  // cropped window opens and closes this early
`define CROP_VS_TAIL 2    // lines after vsync end

`endif

// File: source/video_geom_pkg.sv
//************************************************
// video geometry types
// raster counts, crop offsets, measured geometry
// and the raw timing bundle from the video chip
//************************************************

`default_nettype none

`include "crop_defines.svh"

package video_geom_pkg;

	typedef logic [`CROP_CNT_W-1:0] cnt_t;

	// msb of vbl_b set means the bottom edge counts back from the last line
	typedef struct packed {
		cnt_t hbl_l;
		cnt_t hbl_r;
		cnt_t vbl_t;
		cnt_t vbl_b;
	} crop_t;

	typedef logic [1:0] res_t;

	typedef struct packed {
		cnt_t hsize;
		cnt_t vsize;
		res_t res;
	} geom_t;

	// syncs are active low as the chip drives them
	typedef struct packed {
		logic hs_n;
		logic vs_n;
		logic hblank;
		logic vblank;
	} raw_video_t;

endpackage

`default_nettype wire

// File: source/key_codes_pkg.sv
//************************************************
// keyboard event types
// event bundle from the host and the raw key
// codes used by the crop controller
//************************************************

`default_nettype none

package key_codes_pkg;

	// a new event is flagged by a toggle of level
	typedef struct packed {
		logic [7:0] code;
		logic [1:0] kind;
		logic       level;
	} kbd_event_t;

	localparam logic [1:0] kind_key = 2'd3; // keyboard events

	typedef enum logic [7:0] {
		key_bksp     = 8'h41,
		key_up       = 8'h4C,
		key_down     = 8'h4D,
		key_right    = 8'h4E,
		key_left     = 8'h4F,
		key_alt_l    = 8'h64,
		key_alt_r    = 8'h65,
		key_alt_l_up = 8'hE4, // release codes carry bit 7
		key_alt_r_up = 8'hE5
	} key_code_t;

endpackage

`default_nettype wire

// File: source/line_timer.sv
//************************************************
// line timer
// measures each raw line and builds the cropped
// horizontal blank together with the forced edges
//************************************************

`default_nettype none

`include "crop_defines.svh"

module line_timer (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  video_geom_pkg::raw_video_t raw,
	input  video_geom_pkg::crop_t      crop,
	input  logic                       first_line,
	output logic                       hbl,
	output video_geom_pkg::cnt_t       hsize
);
	import video_geom_pkg::*;

	logic old_hs;
	logic old_hblank;
	cnt_t hcnt;
	cnt_t hend; // source blank end
	cnt_t hsta; // source blank start
	cnt_t hmax; // line length
	cnt_t shbl_clr_pt;
	cnt_t shbl_set_pt;
	cnt_t fhbl_set_pt;
	logic shbl;
	logic fhbl;

	assign shbl_clr_pt = hend + crop.hbl_l - cnt_t'(`CROP_SHBL_LEAD);
	assign shbl_set_pt = hsta + crop.hbl_r - cnt_t'(`CROP_SHBL_LEAD);
	assign fhbl_set_pt = hmax - cnt_t'(`CROP_H_EDGE);

	assign hbl = shbl | fhbl | ~raw.hs_n; // sync always blanks

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs <= 1'b0;
			old_hblank <= 1'b0;
			hcnt <= '0;
			hend <= '0;
			hsta <= '0;
			hmax <= '0;
			shbl <= 1'b1;
			fhbl <= 1'b1;
			hsize <= '0;
		end else begin
			old_hs <= raw.hs_n;
			old_hblank <= raw.hblank;

			hcnt <= hcnt + cnt_t'(1);
			if (~raw.hs_n)
				hcnt <= '0; // held at zero through sync

			if (old_hblank & ~raw.hblank) hend <= hcnt;
			if (~old_hblank & raw.hblank) hsta <= hcnt;
			if (old_hs & ~raw.hs_n)       hmax <= hcnt;

			if (hcnt == shbl_clr_pt) shbl <= 1'b0;
			if (hcnt == shbl_set_pt) shbl <= 1'b1;

			// forced margins
			if (hcnt == cnt_t'(`CROP_H_EDGE)) fhbl <= 1'b0;
			if (hcnt == fhbl_set_pt)          fhbl <= 1'b1;

			if (~old_hblank & raw.hblank & first_line)
				hsize <= hcnt - hend; // visible width
		end
	end

endmodule

`default_nettype wire

// File: source/frame_timer.sv
//************************************************
// frame timer
// counts lines, measures the visible height and
// builds the vertical window and display enable
//************************************************

`default_nettype none

`include "crop_defines.svh"

module frame_timer (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  video_geom_pkg::raw_video_t raw,
	input  video_geom_pkg::crop_t      crop,
	input  logic                       hbl,
	input  video_geom_pkg::cnt_t       hsize,
	input  video_geom_pkg::res_t       res,
	output logic                       first_line,
	output logic                       vbl_end,
	output logic                       de,
	output video_geom_pkg::geom_t      geom
);
	import video_geom_pkg::*;

	logic vblank; // source vblank or vsync
	logic old_vs;
	logic old_hs;
	logic old_vblank;
	logic old_hbl;
	cnt_t vcnt;
	cnt_t vend;
	cnt_t vmax;
	cnt_t vs_end;
	cnt_t vsize;
	cnt_t svbl_clr_pt;
	cnt_t svbl_set_pt;
	cnt_t fvbl_set_pt;
	cnt_t fvbl_clr_pt;
	logic svbl;
	logic fvbl;

	assign vblank = raw.vblank | ~raw.vs_n;

	assign svbl_clr_pt = vend + crop.vbl_t;
	assign svbl_set_pt = crop.vbl_b[`CROP_CNT_W-1] ? vmax + crop.vbl_b : crop.vbl_b;
	assign fvbl_set_pt = vmax - cnt_t'(1);
	assign fvbl_clr_pt = vs_end + cnt_t'(`CROP_VS_TAIL);

	assign first_line = (vcnt == cnt_t'(1));
	assign vbl_end = old_vblank & ~vblank;
	assign geom = '{hsize: hsize, vsize: vsize, res: res};

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vs <= 1'b0;
			old_hs <= 1'b0;
			old_vblank <= 1'b0;
			old_hbl <= 1'b0;
			vcnt <= '0;
			vend <= '0;
			vmax <= '0;
			vs_end <= '0;
			vsize <= '0;
			svbl <= 1'b1;
			fvbl <= 1'b1;
			de <= 1'b0;
		end else begin
			old_vs <= raw.vs_n;
			old_hs <= raw.hs_n;
			old_vblank <= vblank;
			old_hbl <= hbl;

			if (old_hs & ~raw.hs_n) vcnt <= vcnt + cnt_t'(1);
			if (~old_vblank & vblank) begin
				vcnt <= '0;
				vmax <= vcnt; // last line of the frame
				vsize <= vcnt - vend;
			end
			if (old_vblank & ~vblank) vend <= vcnt;
			if (~old_vs & raw.vs_n)   vs_end <= vcnt;

			// vertical edges only move at the start of the visible line
			if ((old_hbl & ~hbl) | (vcnt == '0)) begin
				if (vcnt == svbl_clr_pt) svbl <= 1'b0;
				if (vcnt == svbl_set_pt) svbl <= 1'b1;
				if (vcnt == fvbl_set_pt) fvbl <= 1'b1;
				if (vcnt == fvbl_clr_pt) fvbl <= 1'b0;
			end

			de <= ~(hbl | svbl | fvbl);
		end
	end

endmodule

`default_nettype wire

// File: source/crop_keys.sv
//************************************************
// keyboard crop controller
// arrow keys move the window edges, alt picks the
// opposite edge, backspace clears all offsets
//************************************************

`default_nettype none

`include "crop_defines.svh"

module crop_keys (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  key_codes_pkg::kbd_event_t kbd,
	output video_geom_pkg::crop_t     crop
);
	import video_geom_pkg::*;
	import key_codes_pkg::*;

	localparam cnt_t h_step = cnt_t'(`CROP_H_STEP);
	localparam cnt_t v_step = cnt_t'(`CROP_V_STEP);

	logic old_level;
	logic alt; // either alt key held
	logic key_evt;

	assign key_evt = (old_level ^ kbd.level) && (kbd.kind == kind_key);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			alt <= 1'b0;
			crop <= '0;
		end else begin
			old_level <= kbd.level;
			if (key_evt) begin
				case (kbd.code)
					key_bksp: crop <= '0;
					key_up: begin
						if (alt) crop.vbl_b <= crop.vbl_b + v_step;
						else     crop.vbl_t <= crop.vbl_t + v_step;
					end
					key_down: begin
						if (alt) crop.vbl_b <= crop.vbl_b - v_step;
						else     crop.vbl_t <= crop.vbl_t - v_step;
					end
					key_left: begin
						if (alt) crop.hbl_r <= crop.hbl_r + h_step;
						else     crop.hbl_l <= crop.hbl_l + h_step;
					end
					key_right: begin
						if (alt) crop.hbl_r <= crop.hbl_r - h_step;
						else     crop.hbl_l <= crop.hbl_l - h_step;
					end
					key_alt_l, key_alt_r:       alt <= 1'b1;
					key_alt_l_up, key_alt_r_up: alt <= 1'b0;
					default: ; // other keys pass by
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: source/frame_latch.sv
//************************************************
// frame snapshot
// copies a live value at the end of vblank and
// steps a sequence count when the value changed
//************************************************

`default_nettype none

module frame_latch #(
	parameter type payload_t = logic [7:0]
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       vbl_end,
	input  payload_t   live,
	output payload_t   shot,
	output logic [7:0] seq
);

	logic changed;

	// compare against the value held from the previous frame
	assign changed = (live != shot);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			shot <= '0;
			seq <= '0;
		end else if (vbl_end) begin
			shot <= live;
			if (changed)
				seq <= seq + 8'd1; // wraps
		end
	end

endmodule

`default_nettype wire

// File: source/crop_top.sv
//************************************************
// video crop and geometry tracker
// line and frame timers, keyboard crop control and
// per-frame snapshots of offsets and geometry
//************************************************

`default_nettype none

module crop_top (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  video_geom_pkg::raw_video_t raw,
	input  video_geom_pkg::res_t       res,
	input  key_codes_pkg::kbd_event_t  kbd,
	output logic                       de,
	output video_geom_pkg::crop_t      crop_shot,
	output logic [7:0]                 crop_seq,
	output video_geom_pkg::geom_t      geom_shot,
	output logic [7:0]                 geom_seq
);
	import video_geom_pkg::*;

	crop_t crop_live;
	geom_t geom_live;
	cnt_t  hsize;
	logic  hbl;
	logic  first_line;
	logic  vbl_end;

	crop_keys u_keys (
		.clk_sys (clk_sys),
		.reset   (reset),
		.kbd     (kbd),
		.crop    (crop_live)
	);

	line_timer u_line (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.raw        (raw),
		.crop       (crop_live),
		.first_line (first_line),
		.hbl        (hbl),
		.hsize      (hsize)
	);

	frame_timer u_frame (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.raw        (raw),
		.crop       (crop_live),
		.hbl        (hbl),
		.hsize      (hsize),
		.res        (res),
		.first_line (first_line),
		.vbl_end    (vbl_end),
		.de         (de),
		.geom       (geom_live)
	);

	// both snapshots taken on the same vblank end
	frame_latch #(.payload_t(crop_t)) u_crop_latch (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vbl_end (vbl_end),
		.live    (crop_live),
		.shot    (crop_shot),
		.seq     (crop_seq)
	);

	frame_latch #(.payload_t(geom_t)) u_geom_latch (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vbl_end (vbl_end),
		.live    (geom_live),
		.shot    (geom_shot),
		.seq     (geom_seq)
	);

endmodule

`default_nettype wire

// File: tb/tb_crop_top.sv
//**************************************************
// crop tracker testbench
// random raster frames and key events in vblank,
// checked against a reference model of the offsets,
// the measured geometry and the display window
//**************************************************

`default_nettype none

`include "crop_defines.svh"

module tb_crop_top;
	timeunit 1ns;
	timeprecision 100ps;
	import video_geom_pkg::*;
	import key_codes_pkg::*;

	localparam int n_frames = 22;
	localparam int n_geom = 7;

	logic       clk_sys;
	logic       reset;
	raw_video_t raw;
	res_t       res;
	kbd_event_t kbd;
	logic       de;
	crop_t      crop_shot;
	logic [7:0] crop_seq;
	geom_t      geom_shot;
	logic [7:0] geom_seq;

	// generated raster geometries
	int   g_len[n_geom];
	int   g_sync[n_geom];
	int   g_bend[n_geom];
	int   g_bsta[n_geom];
	int   g_lines[n_geom];
	int   g_vb[n_geom];
	res_t g_res[n_geom];

	// reference model
	crop_t      m_crop;
	crop_t      m_crop_prev;
	logic       m_alt;
	logic [7:0] m_crop_seq;
	geom_t      m_geom_prev;
	logic [7:0] m_geom_seq;

	int checks[1:5];
	int errs[1:5];
	int cycles;
	int cycle_limit;
	logic [7:0] rand_codes[10];

	crop_top DUT (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.raw       (raw),
		.res       (res),
		.kbd       (kbd),
		.de        (de),
		.crop_shot (crop_shot),
		.crop_seq  (crop_seq),
		.geom_shot (geom_shot),
		.geom_seq  (geom_seq)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: run went past %0d clock cycles", cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic int pick(input int lo, input int hi);
		return lo + int'($urandom % 32'(hi - lo + 1));
	endfunction

	function automatic int frame_geom(input int f);
		return (f < 18) ? f / 3 : 6; // last four frames share one raster
	endfunction

	// de-high clocks per line from the blank edges, crop and margins
	function automatic int window_width(input int g, input int hl, input int hr);
		int s;
		int e;
		s = g_bend[g] + hl - `CROP_SHBL_LEAD;
		if (s < g_sync[g] + `CROP_H_EDGE) s = g_sync[g] + `CROP_H_EDGE;
		e = g_bsta[g] + hr - `CROP_SHBL_LEAD;
		if (e > g_len[g] - `CROP_H_EDGE) e = g_len[g] - `CROP_H_EDGE;
		return (e > s) ? e - s : 0;
	endfunction

	task automatic compare_field(input int t, input string name, input int got, input int exp);
		checks[t]++;
		assert (got == exp) else begin
			$display("MISMATCH t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
			errs[t]++;
		end
	endtask

	task automatic send_key(input logic [7:0] code, input logic [1:0] kind);
		kbd.code = code;
		kbd.kind = kind;
		kbd.level = ~kbd.level;
		if (kind == kind_key) begin
			case (code)
				key_bksp: m_crop = '0;
				key_up:
					if (m_alt) m_crop.vbl_b = m_crop.vbl_b + cnt_t'(`CROP_V_STEP);
					else       m_crop.vbl_t = m_crop.vbl_t + cnt_t'(`CROP_V_STEP);
				key_down:
					if (m_alt) m_crop.vbl_b = m_crop.vbl_b - cnt_t'(`CROP_V_STEP);
					else       m_crop.vbl_t = m_crop.vbl_t - cnt_t'(`CROP_V_STEP);
				key_left:
					if (m_alt) m_crop.hbl_r = m_crop.hbl_r + cnt_t'(`CROP_H_STEP);
					else       m_crop.hbl_l = m_crop.hbl_l + cnt_t'(`CROP_H_STEP);
				key_right:
					if (m_alt) m_crop.hbl_r = m_crop.hbl_r - cnt_t'(`CROP_H_STEP);
					else       m_crop.hbl_l = m_crop.hbl_l - cnt_t'(`CROP_H_STEP);
				key_alt_l, key_alt_r:       m_alt = 1'b1;
				key_alt_l_up, key_alt_r_up: m_alt = 1'b0;
				default: ;
			endcase
		end
	endtask

	// runs right after the clock edge that ends vblank
	task automatic check_snapshots(input int f);
		geom_t exp_geom;
		int g;
		g = frame_geom(f);
		if (m_crop != m_crop_prev) m_crop_seq = m_crop_seq + 8'd1;
		m_crop_prev = m_crop;
		compare_field(2, "crop_shot.hbl_l", int'(crop_shot.hbl_l), int'(m_crop.hbl_l));
		compare_field(2, "crop_shot.hbl_r", int'(crop_shot.hbl_r), int'(m_crop.hbl_r));
		compare_field(2, "crop_shot.vbl_t", int'(crop_shot.vbl_t), int'(m_crop.vbl_t));
		compare_field(2, "crop_shot.vbl_b", int'(crop_shot.vbl_b), int'(m_crop.vbl_b));
		compare_field(2, "crop_seq", int'(crop_seq), int'(m_crop_seq));
		// width comes from line 1 and height from the previous frame
		exp_geom.hsize = cnt_t'(g_bsta[g] - g_bend[g]);
		exp_geom.vsize = (f == 0) ? '0 :
			cnt_t'(g_lines[frame_geom(f - 1)] - g_vb[frame_geom(f - 1)]);
		exp_geom.res = g_res[g];
		if (exp_geom != m_geom_prev) m_geom_seq = m_geom_seq + 8'd1;
		m_geom_prev = exp_geom;
		compare_field(3, "geom_shot.hsize", int'(geom_shot.hsize), int'(exp_geom.hsize));
		compare_field(3, "geom_shot.vsize", int'(geom_shot.vsize), int'(exp_geom.vsize));
		compare_field(3, "geom_shot.res", int'(geom_shot.res), int'(exp_geom.res));
		compare_field(4, "geom_seq", int'(geom_seq), int'(m_geom_seq));
	endtask

	task automatic run_frame(input int f);
		int g;
		int p;
		int de_cnt;
		int w;
		int full_lines;
		int part_lines;
		int max_cnt;
		g = frame_geom(f);
		w = window_width(g, int'(m_crop.hbl_l), int'(m_crop.hbl_r));
		full_lines = 0;
		part_lines = 0;
		max_cnt = 0;
		for (int ln = 0; ln < g_lines[g]; ln++) begin
			de_cnt = 0;
			for (p = 0; p < g_len[g]; p++) begin
				raw.hs_n = (p >= g_sync[g]);
				raw.hblank = (p < g_bend[g]) || (p >= g_bsta[g]);
				raw.vblank = (ln < g_vb[g]);
				raw.vs_n = !(ln >= 1 && ln <= g_vb[g] - 2);
				res = g_res[g];
				if (p == 2 && ln >= 1 && ln <= g_vb[g] - 2) begin
					if (f >= 1 && f < 18 && pick(0, 1) == 1)
						send_key(rand_codes[pick(0, 9)],
							(pick(0, 4) == 0) ? 2'(pick(0, 2)) : kind_key);
					else if (f == 18 && ln == 1) send_key(key_bksp, kind_key);
					else if (f == 18 && ln == 2) send_key(key_alt_l_up, kind_key);
					else if (f == 18 && ln == 3) send_key(key_alt_r_up, kind_key);
					else if (f == 20 && ln <= 2) send_key(key_left, kind_key);
				end
				@(posedge clk_sys);
				#1;
				if (de) de_cnt++;
				if (f == 0 && ln < g_vb[g]) begin
					compare_field(1, "de", int'(de), 0);
					compare_field(1, "crop_shot", int'(crop_shot != '0), 0);
					compare_field(1, "geom_shot", int'(geom_shot != '0), 0);
					compare_field(1, "crop_seq", int'(crop_seq), 0);
					compare_field(1, "geom_seq", int'(geom_seq), 0);
				end
				if (ln == g_vb[g] && p == 0) check_snapshots(f);
			end
			if (de_cnt == w && w > 0) full_lines++;
			else if (de_cnt != 0) part_lines++; // cut where a vertical edge moves
			if (de_cnt > max_cnt) max_cnt = de_cnt;
		end
		if (f == 19 || f == 21) begin
			// visible lines run from vb to the last line minus one
			// and both edge lines are cut at the hbl fall
			compare_field(5, "de_clocks_per_line", max_cnt, w);
			compare_field(5, "full_window_lines", full_lines, g_lines[g] - g_vb[g] - 3);
			compare_field(5, "cut_window_lines", part_lines, 2);
		end
	endtask

	initial begin
		int total;
		void'($urandom(5));
		rand_codes = '{key_bksp, key_up, key_down, key_left, key_right,
			key_alt_l, key_alt_r, key_alt_l_up, key_alt_r_up, 8'h20};
		total = 0;
		for (int g = 0; g < n_geom; g++) begin
			g_len[g] = pick(120, 200);
			g_sync[g] = pick(6, 12);
			g_bend[g] = g_sync[g] + pick(10, 20);
			g_bsta[g] = g_len[g] - pick(10, 20);
			g_lines[g] = pick(20, 30);
			g_vb[g] = pick(8, 10);
			g_res[g] = res_t'(pick(0, 3));
		end
		for (int f = 0; f < n_frames; f++)
			total += g_len[frame_geom(f)] * g_lines[frame_geom(f)];
		cycle_limit = total + 2000;
		cycles = 0;
		raw = '{hs_n: 1'b1, vs_n: 1'b1, hblank: 1'b1, vblank: 1'b0};
		res = '0;
		kbd = '0;
		m_crop = '0;
		m_crop_prev = '0;
		m_alt = 1'b0;
		m_crop_seq = '0;
		m_geom_prev = '0;
		m_geom_seq = '0;
		for (int t = 1; t <= 5; t++) begin
			checks[t] = 0;
			errs[t] = 0;
		end
		reset = 1'b1;
		repeat (3) @(posedge clk_sys);
		#1 reset = 1'b0;

		for (int f = 0; f < n_frames; f++) begin
			run_frame(f);
			if (f == 0)
				$display("test 1 reset state: %0d checks, %0d errors", checks[1], errs[1]);
		end
		$display("test 2 crop snapshots: %0d checks, %0d errors", checks[2], errs[2]);
		$display("test 3 geometry: %0d checks, %0d errors", checks[3], errs[3]);
		$display("test 4 geometry sequence: %0d checks, %0d errors", checks[4], errs[4]);
		$display("test 5 display window: %0d checks, %0d errors", checks[5], errs[5]);
		total = 0;
		for (int t = 1; t <= 5; t++) total += errs[t];
		$display("totals: %0d checks, %0d errors",
			checks[1] + checks[2] + checks[3] + checks[4] + checks[5], total);
		if (total == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: crop_top.f
+incdir+source
source/video_geom_pkg.sv
source/key_codes_pkg.sv
source/line_timer.sv
source/frame_timer.sv
source/crop_keys.sv
source/frame_latch.sv
source/crop_top.sv
tb/tb_crop_top.sv

// File: Makefile
# Verilator build and run of the crop tracker testbench

VERILATOR ?= verilator
TOP       ?= tb_crop_top
FLIST     ?= crop_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) source/*.sv source/*.svh tb/*.sv
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Test OK" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
